// ==== source/bram_params.svh ====
`ifndef BRAM_PARAMS_SVH
`define BRAM_PARAMS_SVH

// ---------------------------------------------------------------------------
// memory geometry.
// ---------------------------------------------------------------------------
`define MEM_ADDR_WIDTH 10
`define MEM_DATA_WIDTH 32
`define MEM_CHUNK      8
`define MEM_BE_WIDTH   (`MEM_DATA_WIDTH / `MEM_CHUNK)  // one enable per byte lane.
`define MEM_SIZE       1024

// second output register of the RAM, 1 adds a cycle of read latency.
`define MEM_PIPELINED  1

// response slots, which is also the number of credits handed out after reset.
`define RSP_DEPTH      4

`endif

// ==== source/mem_data_pkg.sv ====
`include "bram_params.svh"

package mem_data_pkg;

   // ------------------------------------------------------------------------
   // data-path types shared by the access stage, the buffer and the top.
   // ------------------------------------------------------------------------

   // word address into the RAM.
   typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

   // one memory word as stored and as returned to the client.
   typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

   // byte-enable mask. An all-zero mask is a read.
   typedef logic [`MEM_BE_WIDTH-1:0]   be_t;

endpackage

// ==== source/mem_ctrl_pkg.sv ====
`include "bram_params.svh"

package mem_ctrl_pkg;

   // number of credits the client can hold, 0 up to RSP_DEPTH.
   typedef logic [$clog2(`RSP_DEPTH + 1)-1:0] credit_t;

   // initial credits are issued in CR_INIT, one per cycle.
   typedef enum logic {
      CR_INIT,
      CR_RUN
   } credit_state_t;

endpackage

// ==== source/bram_1be.sv ====
`timescale 1ns/1ps

module bram_1be #(
   parameter int PIPELINED  = 0,
   parameter int ADDR_WIDTH = 1,
   parameter int DATA_WIDTH = 8,
   parameter int CHUNKSIZE  = 8,
   parameter int WE_WIDTH   = 1,
   parameter int MEMSIZE    = 2
) (
   input  logic                  CLK,
   input  logic                  en,
   input  logic [WE_WIDTH-1:0]   we,
   input  logic [ADDR_WIDTH-1:0] addr,
   input  logic [DATA_WIDTH-1:0] di,
   output logic [DATA_WIDTH-1:0] dout
);

   logic [DATA_WIDTH-1:0] ram [0:MEMSIZE-1];
   logic [DATA_WIDTH-1:0] dout_r;   // first output register.
   logic [DATA_WIDTH-1:0] dout_r2;  // optional second stage.

   // ------------------------------------------------------------------------
   // array and first output register.
   // ------------------------------------------------------------------------
   // each lane is write-first on its own. A written lane shows the new byte
   // on the output, an unwritten lane shows what was already stored.
   always_ff @(posedge CLK) begin
      if (en) begin
         for (int i = 0; i < WE_WIDTH; i++) begin
            if (we[i]) begin
               ram[addr][i*CHUNKSIZE +: CHUNKSIZE] <= di[i*CHUNKSIZE +: CHUNKSIZE];
               dout_r[i*CHUNKSIZE +: CHUNKSIZE]    <= di[i*CHUNKSIZE +: CHUNKSIZE];
            end else begin
               dout_r[i*CHUNKSIZE +: CHUNKSIZE]    <= ram[addr][i*CHUNKSIZE +: CHUNKSIZE];
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // output stage.
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK) begin
      dout_r2 <= dout_r;  // follows every cycle, the valid tracking is outside.
   end

   assign dout = (PIPELINED != 0) ? dout_r2 : dout_r;

endmodule

// ==== source/bram_access.sv ====
`timescale 1ns/1ps

module bram_access #(
   parameter int PIPELINED = 1
) (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                req_valid,
   input  mem_data_pkg::be_t   req_be,
   input  mem_data_pkg::addr_t req_addr,
   input  mem_data_pkg::data_t req_wdata,
   output logic                push,
   output mem_data_pkg::data_t push_data
);

   `include "bram_params.svh"

   import mem_data_pkg::*;

   // cycles from an accepted request to its word at the RAM output.
   localparam int LAT = 1 + ((PIPELINED != 0) ? 1 : 0);

   logic [LAT-1:0] vld_q;  // one bit per RAM stage in flight.
   data_t          ram_dout;

   // the request port drives the RAM directly. A request cannot be refused,
   // so the enable is just req_valid.
   bram_1be #(
      .PIPELINED  (PIPELINED),
      .ADDR_WIDTH ($bits(addr_t)),
      .DATA_WIDTH ($bits(data_t)),
      .CHUNKSIZE  (`MEM_CHUNK),
      .WE_WIDTH   ($bits(be_t)),
      .MEMSIZE    (`MEM_SIZE)
   ) u_ram (
      .CLK  (CLK),
      .en   (req_valid),
      .we   (req_be),
      .addr (req_addr),
      .di   (req_wdata),
      .dout (ram_dout)
   );

   // ------------------------------------------------------------------------
   // valid pipeline, same depth as the RAM read path.
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= req_valid;
         for (int i = 1; i < LAT; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   assign push      = vld_q[LAT-1];  // the RAM output now holds a requested word.
   assign push_data = ram_dout;

   // a pushed word comes from a request that was written or read before, so
   // it must be fully known by the time it leaves the RAM.
   a_push_data_known: assert property (
      @(posedge CLK) disable iff (!rst_n) push |-> !$isunknown(push_data)
   ) else $error("bram_access: unknown word pushed to the response buffer.");

endmodule

// ==== source/rsp_fifo.sv ====
`timescale 1ns/1ps

module rsp_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                push,
   input  mem_data_pkg::data_t push_data,
   output logic                rsp_valid,
   output mem_data_pkg::data_t rsp_data,
   input  logic                rsp_ready,
   output logic                pop_done
);

   import mem_data_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   data_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             pop;

   // wrap at DEPTH so any slot count works, not only powers of two.
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return p + PTR_W'(1);
   endfunction

   assign rsp_valid = (count != '0);
   assign rsp_data  = mem[rd_ptr];  // head of the buffer.
   assign pop       = rsp_valid && rsp_ready;
   assign pop_done  = pop;          // one pulse per transfer to the client.

   // storage.
   always_ff @(posedge CLK) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // ------------------------------------------------------------------------
   // pointers and occupancy.
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push && !pop) begin
            count <= count + CNT_W'(1);
         end else if (pop && !push) begin
            count <= count - CNT_W'(1);
         end
      end
   end

   // credits and slots are the same resource, so a full buffer never sees a
   // push as long as the client keeps to its credits.
   a_no_push_when_full: assert property (
      @(posedge CLK) disable iff (!rst_n) push |-> (count != CNT_W'(DEPTH))
   ) else $error("rsp_fifo: push while the response buffer is full.");

endmodule

// ==== source/credit_ctrl.sv ====
`timescale 1ns/1ps

module credit_ctrl #(
   parameter int DEPTH = 4
) (
   input  logic CLK,
   input  logic rst_n,
   input  logic req_valid,
   input  logic pop_done,
   output logic credit_return
);

   import mem_ctrl_pkg::*;

   credit_state_t state;
   credit_t       init_cnt;  // initial credits issued so far.
   credit_t       held;      // credits currently held by the client.

   // ------------------------------------------------------------------------
   // credit issue FSM.
   // ------------------------------------------------------------------------
   // credit_return is registered, so it stays low through reset and the
   // first credit shows up one cycle after rst_n is released.
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state         <= CR_INIT;
         init_cnt      <= '0;
         credit_return <= 1'b0;
      end else begin
         case (state)
            CR_INIT: begin
               credit_return <= 1'b1;
               init_cnt      <= init_cnt + credit_t'(1);
               if (init_cnt == credit_t'(DEPTH - 1)) begin
                  state <= CR_RUN;  // all DEPTH credits are out.
               end
            end
            CR_RUN: begin
               credit_return <= pop_done;  // a freed slot goes back one cycle later.
            end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // client-side credit count.
   // ------------------------------------------------------------------------
   // the client sees a credit on the edge where credit_return is high, and
   // spends one on every edge where it has req_valid high.
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         held <= '0;
      end else begin
         held <= held + credit_t'(credit_return) - credit_t'(req_valid);
      end
   end

   a_req_needs_credit: assert property (
      @(posedge CLK) disable iff (!rst_n) req_valid |-> (held != '0)
   ) else $error("credit_ctrl: request issued without a credit.");

endmodule

// ==== source/bram_server_top.sv ====
`timescale 1ns/1ps

module bram_server_top (
   input  logic                CLK,
   input  logic                rst_n,
   // request channel, credit controlled.
   input  logic                req_valid,
   input  mem_data_pkg::be_t   req_be,
   input  mem_data_pkg::addr_t req_addr,
   input  mem_data_pkg::data_t req_wdata,
   output logic                credit_return,
   // response channel, valid/ready.
   output logic                rsp_valid,
   output mem_data_pkg::data_t rsp_data,
   input  logic                rsp_ready
);

   `include "bram_params.svh"

   import mem_data_pkg::*;
   import mem_ctrl_pkg::*;

   logic  push;
   data_t push_data;
   logic  pop_done;

   // ------------------------------------------------------------------------
   // RAM access stage, response buffer and credit return.
   // ------------------------------------------------------------------------
   bram_access #(
      .PIPELINED (`MEM_PIPELINED)
   ) u_access (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_be    (req_be),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .push      (push),
      .push_data (push_data)
   );

   rsp_fifo #(
      .DEPTH (`RSP_DEPTH)
   ) u_rsp_fifo (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_ready (rsp_ready),
      .pop_done  (pop_done)
   );

   credit_ctrl #(
      .DEPTH (`RSP_DEPTH)  // one initial credit per buffer slot.
   ) u_credit (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .pop_done      (pop_done),
      .credit_return (credit_return)
   );

endmodule

// ==== test/tb_bram_server.sv ====
`timescale 1ns/1ps

`include "bram_params.svh"

module tb_bram_server;

   import mem_data_pkg::*;

   typedef struct {
      be_t    be;
      addr_t  addr;
      data_t  wdata;
      integer count;  // requests issued by this row.
      integer stall;  // cycles with rsp_ready low at the start of the row.
      bit     rnd;    // random mask, address, data and back-pressure.
      string  name;
   } row_t;

   localparam integer NUM_ROWS = 11;

   logic  CLK;
   logic  rst_n;
   logic  req_valid;
   be_t   req_be;
   addr_t req_addr;
   data_t req_wdata;
   logic  credit_return;
   logic  rsp_valid;
   data_t rsp_data;
   logic  rsp_ready;

   row_t   rows [NUM_ROWS];
   data_t  ref_mem [`MEM_SIZE];  // reference copy of the RAM contents.
   data_t  exp_q [$];            // expected words in request order.
   integer seed;
   integer credits;              // credits held by the client model.
   integer credit_pulses;
   integer valid_cycles;
   integer rsp_seen;
   integer checks;
   integer errors;
   integer tests;
   bit     timed_out;

   bram_server_top u_dut (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .req_be        (req_be),
      .req_addr      (req_addr),
      .req_wdata     (req_wdata),
      .credit_return (credit_return),
      .rsp_valid     (rsp_valid),
      .rsp_data      (rsp_data),
      .rsp_ready     (rsp_ready)
   );

   initial CLK = 1'b0;
   always #20 CLK = ~CLK;

   // ------------------------------------------------------------------------
   // checks and reference model.
   // ------------------------------------------------------------------------
   task automatic check_data(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input integer got, input integer exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // written lanes take the new byte, the others keep the stored one.
   function automatic data_t merge_lanes(input data_t old_w, input data_t new_w, input be_t be);
      data_t res;
      res = old_w;
      for (int i = 0; i < `MEM_BE_WIDTH; i++) begin
         if (be[i]) begin
            res[i*`MEM_CHUNK +: `MEM_CHUNK] = new_w[i*`MEM_CHUNK +: `MEM_CHUNK];
         end
      end
      return res;
   endfunction

   // one clock cycle. Outputs are sampled at the falling edge, inputs change
   // 2 ns after the rising edge.
   task automatic tick();
      @(negedge CLK);
      if (credit_return) begin
         credits++;
         credit_pulses++;
      end
      if (rsp_valid) valid_cycles++;
      if (rsp_valid && rsp_ready) begin
         rsp_seen++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("a response arrived while no request was outstanding.");
         end else begin
            check_data("rsp_data", rsp_data, exp_q.pop_front());
         end
      end
      @(posedge CLK);
      #2;
   endtask

   task automatic report_test(input integer num, input string name, input integer err_before);
      tests++;
      if (errors == err_before) begin
         $display("test %0d (%s): ok", num, name);
      end else begin
         $display("test %0d (%s): %0d errors", num, name, errors - err_before);
      end
   endtask

   task automatic load_table();
      rows[0]  = '{4'hF, 10'h010, 32'hDEADBEEF, 1, 0, 1'b0, "full-mask write"};
      rows[1]  = '{4'h0, 10'h010, 32'h0,        1, 0, 1'b0, "read after full write"};
      rows[2]  = '{4'h5, 10'h010, 32'h11223344, 1, 0, 1'b0, "partial write lanes 0 and 2"};
      rows[3]  = '{4'h0, 10'h010, 32'h0,        1, 0, 1'b0, "read after partial write"};
      rows[4]  = '{4'h8, 10'h010, 32'hA5000000, 1, 0, 1'b0, "partial write lane 3"};
      rows[5]  = '{4'hF, 10'h100, 32'h10203040, 8, 0, 1'b0, "back-to-back writes"};
      rows[6]  = '{4'h0, 10'h100, 32'h0,        8, 0, 1'b0, "back-to-back reads"};
      rows[7]  = '{4'hF, 10'h200, 32'hC0DE0000, 6, 12, 1'b0, "writes under back-pressure"};
      rows[8]  = '{4'h0, 10'h200, 32'h0,        6, 12, 1'b0, "reads under back-pressure"};
      rows[9]  = '{4'hF, 10'h3F0, 32'h5A5A0000, 8, 0, 1'b0, "fill random window"};
      rows[10] = '{4'h0, 10'h3F0, 32'h0,        200, 0, 1'b1, "random traffic"};
   endtask

   // ------------------------------------------------------------------------
   // one table row: issue requests on credit, drain, wait for all credits.
   // ------------------------------------------------------------------------
   task automatic run_row(input row_t row);
      integer issued;
      integer cyc;
      integer limit;
      integer pulses_before;
      integer stall_credits;
      addr_t  a;
      be_t    be;
      data_t  wd;
      data_t  exp;
      issued        = 0;
      cyc           = 0;
      stall_credits = 0;
      rsp_seen      = 0;
      limit         = row.count * 20 + row.stall + 200;
      while ((issued < row.count || exp_q.size() != 0 || credits != `RSP_DEPTH)
             && cyc < limit) begin
         if (row.rnd) rsp_ready = (($random(seed) & 3) != 0);
         else rsp_ready = (cyc >= row.stall);
         if (issued < row.count && credits > 0) begin
            if (row.rnd) begin
               be = be_t'($random(seed));
               a  = row.addr + addr_t'($random(seed) & 7);  // eight-word window.
               wd = data_t'($random(seed));
            end else begin
               be = row.be;
               a  = row.addr + addr_t'(issued);
               wd = row.wdata + data_t'(issued);
            end
            exp        = merge_lanes(ref_mem[a], wd, be);
            ref_mem[a] = exp;
            exp_q.push_back(exp);
            req_valid = 1'b1;
            req_be    = be;
            req_addr  = a;
            req_wdata = wd;
            credits--;
            issued++;
         end else begin
            req_valid = 1'b0;
         end
         pulses_before = credit_pulses;
         tick();
         if (!row.rnd && cyc < row.stall && credit_pulses != pulses_before) stall_credits++;
         cyc++;
         if (!row.rnd && row.stall > 0 && cyc == row.stall) begin
            check_count("credits held at end of stall", credits,
                        (row.count >= `RSP_DEPTH) ? 0 : `RSP_DEPTH - row.count);
            check_count("credit_return pulses during stall", stall_credits, 0);
         end
      end
      req_valid = 1'b0;
      rsp_ready = 1'b1;
      if (cyc >= limit) begin
         timed_out = 1'b1;
         $display("timeout: row did not drain, %0d of %0d requests issued and %0d pending.",
                  issued, row.count, exp_q.size());
      end else begin
         check_count("responses received", rsp_seen, row.count);
      end
   endtask

   // ------------------------------------------------------------------------
   // main sequence.
   // ------------------------------------------------------------------------
   initial begin
      integer r;
      integer err_before;
      integer wait_cnt;
      seed          = 75125;
      rst_n         = 1'b0;
      req_valid     = 1'b0;
      req_be        = '0;
      req_addr      = '0;
      req_wdata     = '0;
      rsp_ready     = 1'b1;
      credits       = 0;
      credit_pulses = 0;
      valid_cycles  = 0;
      rsp_seen      = 0;
      checks        = 0;
      errors        = 0;
      tests         = 0;
      timed_out     = 1'b0;
      load_table();
      repeat (2) @(posedge CLK);
      #2;
      rst_n = 1'b1;

      // initial credits, no request sent yet.
      err_before = errors;
      wait_cnt   = 0;
      while (credits < `RSP_DEPTH && wait_cnt < 20) begin
         tick();
         wait_cnt++;
      end
      if (credits < `RSP_DEPTH) begin
         timed_out = 1'b1;
         $display("timeout: the initial credits did not arrive after reset.");
      end
      repeat (4) tick();
      check_count("credit_return pulses", credit_pulses, `RSP_DEPTH);
      check_count("rsp_valid cycles", valid_cycles, 0);
      report_test(0, "initial credits", err_before);

      for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
         err_before = errors;
         run_row(rows[r]);
         report_test(r + 1, rows[r].name, err_before);
      end

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+source
source/mem_data_pkg.sv
source/mem_ctrl_pkg.sv
source/bram_1be.sv
source/bram_access.sv
source/rsp_fifo.sv
source/credit_ctrl.sv
source/bram_server_top.sv
test/tb_bram_server.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BRAM server testbench with Verilator, run from the project root.
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_bram_server -f vlog.f \
   && ./obj_dir/Vtb_bram_server > sim.log 2>&1 \
   || echo ">>> FAIL" >> sim.log

cat sim.log

grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; } \
   || { echo "simulation passed"; exit 0; }
